/* Bender.yml */
package:
  name: armPipeline

sources:
  - armPkg.sv
  - regFile.sv
  - alu.sv
  - datapath.sv
  - controller.sv
  - hazardUnit.sv
  - armPipeline.sv
  - target: simulation
    files:
      - tbArmPipeline.sv

/* alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu import armPkg::*; (
  input  logic [31:0] a,
  input  logic [31:0] b,
  input  aluOpT       aluOp,
  input  logic        carryIn,
  output logic [31:0] result,
  output flagsT       flags,
  output logic        noWrite
);

  logic [31:0] bIn;
  logic        cIn;
  logic        arith;
  logic [32:0] sum;

  // Adder setup, subtraction as a + ~b + 1
  always_comb begin
    bIn = b;
    cIn = 1'b0;
    arith = 1'b1;
    case (aluOp)
      AluSub, AluCmp: begin
        bIn = ~b;
        cIn = 1'b1;
      end
      AluAdc: cIn = carryIn;
      AluSbc: begin
        bIn = ~b;
        cIn = carryIn;
      end
      AluAdd: cIn = 1'b0;
      default: arith = 1'b0;
    endcase
  end

  assign sum = {1'b0, a} + {1'b0, bIn} + {32'd0, cIn};

  always_comb begin
    case (aluOp)
      AluAnd, AluTst: result = a & b;
      AluEor:         result = a ^ b;
      AluOrr:         result = a | b;
      AluMov:         result = b;
      default:        result = sum[31:0];
    endcase
  end

  assign flags.n = result[31];
  assign flags.z = (result == 32'd0);
  // C is "no borrow" for subtraction
  assign flags.c = arith & sum[32];
  assign flags.v = arith & (a[31] == bIn[31]) & (sum[31] != a[31]);

  assign noWrite = (aluOp == AluCmp) || (aluOp == AluTst);

endmodule

`default_nettype wire

/* armPipeline.sv */
`timescale 1ns/1ps
`default_nettype none

module armPipeline import armPkg::*; (
  input  logic        clk,
  input  logic        rstN,
  input  logic [31:0] instrF,
  input  logic [31:0] readDataM,
  output logic [31:0] pcF,
  output logic [31:0] aluOutM,
  output logic [31:0] writeDataM,
  output logic        memWriteM
);

  decodeCtrlT  decodeCtrl;
  aluOpT       aluOpE;
  flagsT       aluFlagsE;
  matchT       match;
  hazardT      hazard;
  logic [31:0] instrD;
  logic        aluSrcE, swapInputsE, prevCarry, branchTakenE;
  logic        memtoRegW, regWriteW, regWriteM, memtoRegE;
  logic        noWriteE, flushE;

  controller u_controller (
    .clk          (clk),
    .rstN         (rstN),
    .instrD       (instrD),
    .aluFlagsE    (aluFlagsE),
    .noWriteE     (noWriteE),
    .flushE       (flushE),
    .decodeCtrl   (decodeCtrl),
    .aluSrcE      (aluSrcE),
    .swapInputsE  (swapInputsE),
    .prevCarry    (prevCarry),
    .branchTakenE (branchTakenE),
    .memWriteM    (memWriteM),
    .memtoRegW    (memtoRegW),
    .regWriteW    (regWriteW),
    .regWriteM    (regWriteM),
    .memtoRegE    (memtoRegE),
    .aluOpE       (aluOpE)
  );

  datapath u_datapath (
    .clk          (clk),
    .rstN         (rstN),
    .decodeCtrl   (decodeCtrl),
    .aluSrcE      (aluSrcE),
    .swapInputsE  (swapInputsE),
    .prevCarry    (prevCarry),
    .branchTakenE (branchTakenE),
    .memtoRegW    (memtoRegW),
    .regWriteW    (regWriteW),
    .aluOpE       (aluOpE),
    .hazard       (hazard),
    .instrF       (instrF),
    .readDataM    (readDataM),
    .pcF          (pcF),
    .instrD       (instrD),
    .aluOutM      (aluOutM),
    .writeDataM   (writeDataM),
    .aluFlagsE    (aluFlagsE),
    .noWriteE     (noWriteE),
    .match        (match)
  );

  hazardUnit u_hazardUnit (
    .match        (match),
    .regWriteM    (regWriteM),
    .regWriteW    (regWriteW),
    .memtoRegE    (memtoRegE),
    .branchTakenE (branchTakenE),
    .hazard       (hazard),
    .flushE       (flushE)
  );

endmodule

`default_nettype wire

/* armPkg.sv */
`default_nettype none

package armPkg;

  typedef enum logic [3:0] {
    AluAnd,
    AluEor,
    AluSub,
    AluAdd,
    AluAdc,
    AluSbc,
    AluOrr,
    AluMov,
    AluCmp,
    AluTst
  } aluOpT;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flagsT;

  // Control bits carried from decode into execute
  typedef struct packed {
    logic       regWrite;
    logic       memWrite;
    logic       memtoReg;
    logic       branch;
    logic       aluSrc;
    logic       flagWrite;
    logic       swapInputs;
    aluOpT      aluOp;
    logic [3:0] cond;
  } ctrlT;

  typedef struct packed {
    logic [1:0] regSrc;
    logic [1:0] immSrc;
  } decodeCtrlT;

  typedef struct packed {
    logic match1EM;
    logic match1EW;
    logic match2EM;
    logic match2EW;
    logic match12DE;
  } matchT;

  typedef struct packed {
    logic [1:0] forwardA;
    logic [1:0] forwardB;
    logic       stallF;
    logic       stallD;
    logic       flushD;
  } hazardT;

  localparam logic [1:0] ForwardReg     = 2'd0;
  localparam logic [1:0] ForwardResultW = 2'd1;
  localparam logic [1:0] ForwardAluOutM = 2'd2;

endpackage

`default_nettype wire

/* controller.sv */
`timescale 1ns/1ps
`default_nettype none

module controller import armPkg::*; (
  input  logic        clk,
  input  logic        rstN,
  input  logic [31:0] instrD,
  input  flagsT       aluFlagsE,
  input  logic        noWriteE,
  input  logic        flushE,
  output decodeCtrlT  decodeCtrl,
  output logic        aluSrcE,
  output logic        swapInputsE,
  output logic        prevCarry,
  output logic        branchTakenE,
  output logic        memWriteM,
  output logic        memtoRegW,
  output logic        regWriteW,
  output logic        regWriteM,
  output logic        memtoRegE,
  output aluOpT       aluOpE
);

  ctrlT  ctrlD, ctrlE;
  flagsT flagsR;
  logic  condEx, arithE, flagWriteE, regWriteE, memWriteE, memtoRegM;

  // Main decoder
  always_comb begin
    ctrlD = '0;
    decodeCtrl = '0;
    ctrlD.cond = instrD[31:28];
    case (instrD[27:26])
      2'b00: begin
        ctrlD.regWrite = 1'b1;
        ctrlD.aluSrc = instrD[25];
        ctrlD.flagWrite = instrD[20];
        case (instrD[24:21])
          4'b0000: ctrlD.aluOp = AluAnd;
          4'b0001: ctrlD.aluOp = AluEor;
          4'b0010: ctrlD.aluOp = AluSub;
          4'b0011: begin
            ctrlD.aluOp = AluSub;
            ctrlD.swapInputs = 1'b1;
          end
          4'b0100: ctrlD.aluOp = AluAdd;
          4'b0101: ctrlD.aluOp = AluAdc;
          4'b0110: ctrlD.aluOp = AluSbc;
          4'b1000: ctrlD.aluOp = AluTst;
          4'b1010: ctrlD.aluOp = AluCmp;
          4'b1100: ctrlD.aluOp = AluOrr;
          4'b1101: ctrlD.aluOp = AluMov;
          default: begin
            ctrlD.regWrite = 1'b0;
            ctrlD.flagWrite = 1'b0;
          end
        endcase
      end
      2'b01: begin
        ctrlD.aluSrc = 1'b1;
        ctrlD.aluOp = AluAdd;
        decodeCtrl.immSrc = 2'b01;
        if (instrD[20]) begin
          ctrlD.regWrite = 1'b1;
          ctrlD.memtoReg = 1'b1;
        end else begin
          ctrlD.memWrite = 1'b1;
          decodeCtrl.regSrc = 2'b10;
        end
      end
      2'b10: begin
        ctrlD.branch = 1'b1;
        ctrlD.aluSrc = 1'b1;
        ctrlD.aluOp = AluAdd;
        decodeCtrl.immSrc = 2'b10;
        decodeCtrl.regSrc = 2'b01;
      end
      default: ctrlD = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstN || flushE) begin
      ctrlE <= '0;
    end else begin
      ctrlE <= ctrlD;
    end
  end

  // Condition check against the stored flags
  always_comb begin
    case (ctrlE.cond)
      4'b0000: condEx = flagsR.z;
      4'b0001: condEx = !flagsR.z;
      4'b0010: condEx = flagsR.c;
      4'b0011: condEx = !flagsR.c;
      4'b0100: condEx = flagsR.n;
      4'b0101: condEx = !flagsR.n;
      4'b0110: condEx = flagsR.v;
      4'b0111: condEx = !flagsR.v;
      4'b1000: condEx = flagsR.c && !flagsR.z;
      4'b1001: condEx = !flagsR.c || flagsR.z;
      4'b1010: condEx = (flagsR.n == flagsR.v);
      4'b1011: condEx = (flagsR.n != flagsR.v);
      4'b1100: condEx = !flagsR.z && (flagsR.n == flagsR.v);
      4'b1101: condEx = flagsR.z || (flagsR.n != flagsR.v);
      default: condEx = 1'b1;
    endcase
  end

  assign regWriteE = ctrlE.regWrite && condEx && !noWriteE;
  assign memWriteE = ctrlE.memWrite && condEx;
  assign flagWriteE = ctrlE.flagWrite && condEx;
  assign branchTakenE = ctrlE.branch && condEx;
  // Logic ops leave C and V alone
  assign arithE = ctrlE.aluOp inside {AluAdd, AluSub, AluAdc, AluSbc, AluCmp};

  always_ff @(posedge clk) begin
    if (!rstN) begin
      flagsR <= '0;
    end else if (flagWriteE) begin
      flagsR.n <= aluFlagsE.n;
      flagsR.z <= aluFlagsE.z;
      if (arithE) begin
        flagsR.c <= aluFlagsE.c;
        flagsR.v <= aluFlagsE.v;
      end
    end
  end

  // Memory and writeback control
  always_ff @(posedge clk) begin
    if (!rstN) begin
      regWriteM <= 1'b0;
      memWriteM <= 1'b0;
      memtoRegM <= 1'b0;
      regWriteW <= 1'b0;
      memtoRegW <= 1'b0;
    end else begin
      regWriteM <= regWriteE;
      memWriteM <= memWriteE;
      memtoRegM <= ctrlE.memtoReg;
      regWriteW <= regWriteM;
      memtoRegW <= memtoRegM;
    end
  end

  assign aluSrcE = ctrlE.aluSrc;
  assign swapInputsE = ctrlE.swapInputs;
  assign aluOpE = ctrlE.aluOp;
  assign memtoRegE = ctrlE.memtoReg;
  assign prevCarry = flagsR.c;

endmodule

`default_nettype wire

/* datapath.sv */
`timescale 1ns/1ps
`default_nettype none

module datapath import armPkg::*; (
  input  logic        clk,
  input  logic        rstN,
  input  decodeCtrlT  decodeCtrl,
  input  logic        aluSrcE,
  input  logic        swapInputsE,
  input  logic        prevCarry,
  input  logic        branchTakenE,
  input  logic        memtoRegW,
  input  logic        regWriteW,
  input  aluOpT       aluOpE,
  input  hazardT      hazard,
  input  logic [31:0] instrF,
  input  logic [31:0] readDataM,
  output logic [31:0] pcF,
  output logic [31:0] instrD,
  output logic [31:0] aluOutM,
  output logic [31:0] writeDataM,
  output flagsT       aluFlagsE,
  output logic        noWriteE,
  output matchT       match
);

  logic [31:0] pcPlus4F, pcNextF;
  logic [31:0] extImmD, rd1D, rd2D;
  logic [31:0] rd1E, rd2E, extImmE, srcAE, srcBE, writeDataE, aluAE, aluBE, aluResultE;
  logic [31:0] aluOutW, readDataW, resultW;
  logic [3:0]  ra1D, ra2D, ra1E, ra2E, wa3E, wa3M, wa3W;

  // Fetch
  assign pcPlus4F = pcF + 32'd4;
  assign pcNextF = branchTakenE ? aluResultE : pcPlus4F;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      pcF <= '0;
    end else if (!hazard.stallF) begin
      pcF <= pcNextF;
    end
  end

  // Decode
  always_ff @(posedge clk) begin
    if (!rstN || hazard.flushD) begin
      instrD <= '0;
    end else if (!hazard.stallD) begin
      instrD <= instrF;
    end
  end

  assign ra1D = decodeCtrl.regSrc[0] ? 4'd15 : instrD[19:16];
  assign ra2D = decodeCtrl.regSrc[1] ? instrD[15:12] : instrD[3:0];

  always_comb begin
    case (decodeCtrl.immSrc)
      2'b00:   extImmD = {24'd0, instrD[7:0]};
      2'b01:   extImmD = {20'd0, instrD[11:0]};
      default: extImmD = {{6{instrD[23]}}, instrD[23:0], 2'b00};
    endcase
  end

  // PC+4 in fetch is PC+8 of the decode instruction
  regFile rf (
    .clk (clk),
    .we3 (regWriteW),
    .ra1 (ra1D),
    .ra2 (ra2D),
    .wa3 (wa3W),
    .wd3 (resultW),
    .r15 (pcPlus4F),
    .rd1 (rd1D),
    .rd2 (rd2D)
  );

  // Execute, memory and writeback registers
  always_ff @(posedge clk) begin
    if (!rstN) begin
      rd1E <= '0;
      rd2E <= '0;
      extImmE <= '0;
      ra1E <= '0;
      ra2E <= '0;
      wa3E <= '0;
      aluOutM <= '0;
      writeDataM <= '0;
      wa3M <= '0;
      aluOutW <= '0;
      readDataW <= '0;
      wa3W <= '0;
    end else begin
      rd1E <= rd1D;
      rd2E <= rd2D;
      extImmE <= extImmD;
      ra1E <= ra1D;
      ra2E <= ra2D;
      wa3E <= instrD[15:12];
      aluOutM <= aluResultE;
      writeDataM <= writeDataE;
      wa3M <= wa3E;
      aluOutW <= aluOutM;
      readDataW <= readDataM;
      wa3W <= wa3M;
    end
  end

  // Forwarding muxes
  always_comb begin
    case (hazard.forwardA)
      ForwardResultW: srcAE = resultW;
      ForwardAluOutM: srcAE = aluOutM;
      default:        srcAE = rd1E;
    endcase
    case (hazard.forwardB)
      ForwardResultW: writeDataE = resultW;
      ForwardAluOutM: writeDataE = aluOutM;
      default:        writeDataE = rd2E;
    endcase
  end

  assign srcBE = aluSrcE ? extImmE : writeDataE;
  // RSB swaps the operands
  assign aluAE = swapInputsE ? srcBE : srcAE;
  assign aluBE = swapInputsE ? srcAE : srcBE;

  alu u_alu (
    .a       (aluAE),
    .b       (aluBE),
    .aluOp   (aluOpE),
    .carryIn (prevCarry),
    .result  (aluResultE),
    .flags   (aluFlagsE),
    .noWrite (noWriteE)
  );

  assign resultW = memtoRegW ? readDataW : aluOutW;

  // Register number comparisons for the hazard unit
  assign match.match1EM = (wa3M == ra1E);
  assign match.match1EW = (wa3W == ra1E);
  assign match.match2EM = (wa3M == ra2E);
  assign match.match2EW = (wa3W == ra2E);
  assign match.match12DE = (wa3E == ra1D) || (wa3E == ra2D);

endmodule

`default_nettype wire

/* filelist.f */
armPkg.sv
regFile.sv
alu.sv
datapath.sv
controller.sv
hazardUnit.sv
armPipeline.sv
tbArmPipeline.sv

/* hazardUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module hazardUnit import armPkg::*; (
  input  matchT  match,
  input  logic   regWriteM,
  input  logic   regWriteW,
  input  logic   memtoRegE,
  input  logic   branchTakenE,
  output hazardT hazard,
  output logic   flushE
);

  logic ldrStall;

  // Memory stage wins over writeback
  always_comb begin
    if (match.match1EM && regWriteM) begin
      hazard.forwardA = ForwardAluOutM;
    end else if (match.match1EW && regWriteW) begin
      hazard.forwardA = ForwardResultW;
    end else begin
      hazard.forwardA = ForwardReg;
    end
    if (match.match2EM && regWriteM) begin
      hazard.forwardB = ForwardAluOutM;
    end else if (match.match2EW && regWriteW) begin
      hazard.forwardB = ForwardResultW;
    end else begin
      hazard.forwardB = ForwardReg;
    end
  end

  // Load result needed right behind the load
  assign ldrStall = match.match12DE && memtoRegE;

  assign hazard.stallF = ldrStall;
  assign hazard.stallD = ldrStall;
  assign hazard.flushD = branchTakenE;
  assign flushE = ldrStall || branchTakenE;

endmodule

`default_nettype wire

/* regFile.sv */
`timescale 1ns/1ps
`default_nettype none

module regFile (
  input  logic        clk,
  input  logic        we3,
  input  logic [3:0]  ra1,
  input  logic [3:0]  ra2,
  input  logic [3:0]  wa3,
  input  logic [31:0] wd3,
  input  logic [31:0] r15,
  output logic [31:0] rd1,
  output logic [31:0] rd2
);

  logic [31:0] rf [15];

  // Falling edge write so decode sees it in the same cycle
  always_ff @(negedge clk) begin
    if (we3) begin
      rf[wa3] <= wd3;
    end
  end

  // R15 reads as PC+8
  assign rd1 = (ra1 == 4'd15) ? r15 : rf[ra1];
  assign rd2 = (ra2 == 4'd15) ? r15 : rf[ra2];

endmodule

`default_nettype wire

/* tbArmPipeline.sv */
`timescale 1ns/1ps
`default_nettype none

module tbArmPipeline;

  localparam logic [3:0] CondEq = 4'h0;
  localparam logic [3:0] CondNe = 4'h1;
  localparam logic [3:0] CondAl = 4'hE;
  localparam logic [3:0] CmdAnd = 4'b0000;
  localparam logic [3:0] CmdEor = 4'b0001;
  localparam logic [3:0] CmdSub = 4'b0010;
  localparam logic [3:0] CmdRsb = 4'b0011;
  localparam logic [3:0] CmdAdd = 4'b0100;
  localparam logic [3:0] CmdAdc = 4'b0101;
  localparam logic [3:0] CmdSbc = 4'b0110;
  localparam logic [3:0] CmdTst = 4'b1000;
  localparam logic [3:0] CmdCmp = 4'b1010;
  localparam logic [3:0] CmdOrr = 4'b1100;
  localparam logic [3:0] CmdMov = 4'b1101;
  // Unsupported opcode that decodes to no write
  localparam logic [3:0] CmdNop = 4'b1111;
  localparam logic [31:0] PoisonValue = 32'h000000EE;
  localparam int EndAddr = 252;
  localparam int RunCycles = 60;
  localparam longint WatchdogNs = 6 * 70 * 100 + 6 * 3 * 100;

  logic        clk;
  logic        rstN;
  logic [31:0] instrF, readDataM, pcF, aluOutM, writeDataM;
  logic        memWriteM;
  logic [31:0] rom [64];
  logic [31:0] dmem [64];
  logic        poisonSeen;
  int          progLen;
  logic [31:0] lfsrState;

  armPipeline UUT (
    .clk        (clk),
    .rstN       (rstN),
    .instrF     (instrF),
    .readDataM  (readDataM),
    .pcF        (pcF),
    .aluOutM    (aluOutM),
    .writeDataM (writeDataM),
    .memWriteM  (memWriteM)
  );

  // Combinational memory reads
  assign instrF = rom[pcF[7:2]];
  assign readDataM = dmem[aluOutM[7:2]];

  always @(posedge clk) begin
    if (memWriteM) begin
      dmem[aluOutM[7:2]] <= writeDataM;
      if (writeDataM == PoisonValue) begin
        poisonSeen <= 1'b1;
      end
    end
  end

  always #50 clk = ~clk;

  initial begin
    #(WatchdogNs);
    $display("Watchdog expired before all tests finished");
    $display("Test failed");
    $fatal(1);
  end

  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    if (actual !== expected) begin
      $display("error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  task automatic drawByte(output logic [7:0] value);
    value = '0;
    for (int i = 0; i < 8; i++) begin
      lfsrState = lfsrNext(lfsrState);
      value = {value[6:0], lfsrState[0]};
    end
  endtask

  // Instruction encoders
  function automatic logic [31:0] dpWord(input logic [3:0] cond, input logic [3:0] cmd,
                                         input logic imm, input logic s, input logic [3:0] rn,
                                         input logic [3:0] rd, input logic [7:0] op2);
    return {cond, 2'b00, imm, cmd, s, rn, rd, 4'b0000, op2};
  endfunction

  function automatic logic [31:0] memWord(input logic load, input logic [3:0] rn,
                                          input logic [3:0] rd, input logic [11:0] offset);
    return {CondAl, 2'b01, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, load, rn, rd, offset};
  endfunction

  function automatic logic [31:0] branchWord(input logic [3:0] cond, input logic [23:0] offset);
    return {cond, 2'b10, 2'b10, offset};
  endfunction

  task automatic emit(input logic [31:0] word);
    rom[progLen] = word;
    progLen++;
  endtask

  task automatic emitImm(input logic [3:0] cond, input logic [3:0] cmd, input logic s,
                         input logic [3:0] rd, input logic [3:0] rn, input logic [7:0] imm);
    emit(dpWord(cond, cmd, 1'b1, s, rn, rd, imm));
  endtask

  task automatic emitReg(input logic [3:0] cmd, input logic s, input logic [3:0] rd,
                         input logic [3:0] rn, input logic [3:0] rm);
    emit(dpWord(CondAl, cmd, 1'b0, s, rn, rd, {4'h0, rm}));
  endtask

  // Each program clears R14 for use as the load and store base
  task automatic emitStore(input logic [3:0] rd, input logic [11:0] offset);
    emit(memWord(1'b0, 4'd14, rd, offset));
  endtask

  task automatic emitNops(input int count);
    for (int i = 0; i < count; i++) begin
      emit(dpWord(CondAl, CmdNop, 1'b0, 1'b0, 4'd0, 4'd0, 8'd0));
    end
  endtask

  // Holds the core in reset while memories are reloaded
  task automatic beginProgram;
    rstN = 1'b0;
    for (int i = 0; i < 64; i++) begin
      rom[i] = dpWord(CondAl, CmdNop, 1'b0, 1'b0, 4'd0, 4'd0, i[7:0]);
      dmem[i] = 32'h5A5A0000 | i;
    end
    poisonSeen = 1'b0;
    progLen = 0;
    emitImm(CondAl, CmdMov, 1'b0, 4'd14, 4'd0, 8'd0);
  endtask

  task automatic resetCore;
    rstN = 1'b0;
    repeat (3) begin
      @(posedge clk);
      #1;
      checkValue("pcF in reset", pcF, 32'd0);
      checkValue("memWriteM in reset", {31'd0, memWriteM}, 32'd0);
    end
    rstN = 1'b1;
  endtask

  task automatic runProgram;
    int  cycles;
    bit  done;
    emitStore(4'd14, 12'(EndAddr));
    resetCore();
    cycles = 0;
    done = 0;
    while (!done && cycles < RunCycles) begin
      @(negedge clk);
      cycles++;
      if (memWriteM && aluOutM == EndAddr) begin
        done = 1;
      end
    end
    if (!done) begin
      $display("Program did not reach its end marker store within %0d cycles", RunCycles);
      $display("Test failed");
      $fatal(1);
    end
    @(posedge clk);
    #1;
  endtask

  task automatic testReset;
    beginProgram();
    resetCore();
    for (int k = 1; k <= 8; k++) begin
      @(posedge clk);
      #1;
      checkValue("pcF", pcF, 32'(4 * k));
      checkValue("memWriteM", {31'd0, memWriteM}, 32'd0);
    end
  endtask

  task automatic testArithmetic;
    logic [7:0]  a, b, c;
    logic [31:0] x, y;
    drawByte(a);
    drawByte(b);
    drawByte(c);
    x = {24'd0, a};
    y = {24'd0, b};
    beginProgram();
    emitImm(CondAl, CmdMov, 1'b0, 4'd1, 4'd0, a);
    emitImm(CondAl, CmdMov, 1'b0, 4'd2, 4'd0, b);
    emitReg(CmdAdd, 1'b0, 4'd3, 4'd1, 4'd2);
    emitReg(CmdSub, 1'b0, 4'd4, 4'd1, 4'd2);
    emitReg(CmdRsb, 1'b0, 4'd5, 4'd1, 4'd2);
    emitReg(CmdAnd, 1'b0, 4'd6, 4'd1, 4'd2);
    emitReg(CmdOrr, 1'b0, 4'd7, 4'd1, 4'd2);
    emitReg(CmdEor, 1'b0, 4'd8, 4'd1, 4'd2);
    emitImm(CondAl, CmdAdd, 1'b0, 4'd9, 4'd1, c);
    for (int r = 1; r <= 9; r++) begin
      if (r != 2) begin
        emitStore(r[3:0], 12'(4 * (r == 1 ? 0 : r - 2)));
      end
    end
    runProgram();
    checkValue("MOV result", dmem[0], x);
    checkValue("ADD result", dmem[1], x + y);
    checkValue("SUB result", dmem[2], x - y);
    checkValue("RSB result", dmem[3], y - x);
    checkValue("AND result", dmem[4], x & y);
    checkValue("ORR result", dmem[5], x | y);
    checkValue("EOR result", dmem[6], x ^ y);
    checkValue("ADD immediate result", dmem[7], x + {24'd0, c});
  endtask

  task automatic emitChain(input logic [7:0] a, input logic [7:0] b, input int gap);
    emitImm(CondAl, CmdMov, 1'b0, 4'd1, 4'd0, a);
    emitNops(gap);
    emitImm(CondAl, CmdAdd, 1'b0, 4'd2, 4'd1, b);
    emitNops(gap);
    emitReg(CmdSub, 1'b0, 4'd3, 4'd2, 4'd1);
    emitNops(gap);
    emitReg(CmdEor, 1'b0, 4'd4, 4'd3, 4'd2);
    emitNops(gap);
    emitReg(CmdOrr, 1'b0, 4'd5, 4'd4, 4'd1);
  endtask

  task automatic testForwarding;
    logic [7:0]  a, b;
    logic [31:0] expected [4];
    drawByte(a);
    drawByte(b);
    expected[0] = {24'd0, a} + {24'd0, b};
    expected[1] = expected[0] - {24'd0, a};
    expected[2] = expected[1] ^ expected[0];
    expected[3] = expected[2] | {24'd0, a};
    beginProgram();
    emitChain(a, b, 0);
    for (int r = 0; r < 4; r++) begin
      emitStore(4'(r + 2), 12'(4 * r));
    end
    emitChain(a, b, 3);
    for (int r = 0; r < 4; r++) begin
      emitStore(4'(r + 2), 12'(16 + 4 * r));
    end
    runProgram();
    for (int r = 0; r < 4; r++) begin
      checkValue($sformatf("back to back R%0d", r + 2), dmem[r], expected[r]);
      checkValue($sformatf("spaced R%0d", r + 2), dmem[4 + r], expected[r]);
    end
  endtask

  task automatic testLoadUse;
    logic [7:0] v, k;
    drawByte(v);
    drawByte(k);
    beginProgram();
    emitImm(CondAl, CmdMov, 1'b0, 4'd1, 4'd0, v);
    emitStore(4'd1, 12'd40);
    emit(memWord(1'b1, 4'd14, 4'd2, 12'd40));
    emitImm(CondAl, CmdAdd, 1'b0, 4'd3, 4'd2, k);
    emitStore(4'd3, 12'd0);
    runProgram();
    checkValue("stored word", dmem[10], {24'd0, v});
    checkValue("load then ADD", dmem[0], {24'd0, v} + {24'd0, k});
  endtask

  task automatic testFlags;
    logic [31:0] carryEq, carryLt;
    // Carry after CMP is set when there is no borrow
    carryEq = (5 >= 5) ? 32'd1 : 32'd0;
    carryLt = (5 >= 7) ? 32'd1 : 32'd0;
    beginProgram();
    emitImm(CondAl, CmdMov, 1'b0, 4'd1, 4'd0, 8'd5);
    emitImm(CondAl, CmdMov, 1'b0, 4'd2, 4'd0, 8'd5);
    emitReg(CmdCmp, 1'b1, 4'd0, 4'd1, 4'd2);
    emitImm(CondEq, CmdMov, 1'b0, 4'd3, 4'd0, 8'h11);
    emitImm(CondNe, CmdMov, 1'b0, 4'd3, 4'd0, 8'h22);
    emitImm(CondAl, CmdAdc, 1'b0, 4'd4, 4'd1, 8'h10);
    emitImm(CondAl, CmdSbc, 1'b0, 4'd5, 4'd1, 8'd2);
    emitImm(CondAl, CmdCmp, 1'b1, 4'd0, 4'd1, 8'd7);
    emitImm(CondEq, CmdMov, 1'b0, 4'd6, 4'd0, 8'h33);
    emitImm(CondNe, CmdMov, 1'b0, 4'd6, 4'd0, 8'h44);
    emitImm(CondAl, CmdAdc, 1'b0, 4'd7, 4'd1, 8'h10);
    emitImm(CondAl, CmdSbc, 1'b0, 4'd8, 4'd1, 8'd2);
    emitImm(CondAl, CmdMov, 1'b0, 4'd9, 4'd0, 8'h5A);
    emitImm(CondAl, CmdTst, 1'b1, 4'd9, 4'd9, 8'hA5);
    emitImm(CondEq, CmdMov, 1'b0, 4'd10, 4'd0, 8'h66);
    for (int r = 3; r <= 10; r++) begin
      emitStore(r[3:0], 12'(4 * (r - 3)));
    end
    runProgram();
    checkValue("MOVEQ after equal CMP", dmem[0], 32'h11);
    checkValue("ADC with carry set", dmem[1], 32'd5 + 32'h10 + carryEq);
    checkValue("SBC with carry set", dmem[2], 32'd5 - 32'd2 - (32'd1 - carryEq));
    checkValue("MOVNE after unequal CMP", dmem[3], 32'h44);
    checkValue("ADC with carry clear", dmem[4], 32'd5 + 32'h10 + carryLt);
    checkValue("SBC with carry clear", dmem[5], 32'd5 - 32'd2 - (32'd1 - carryLt));
    checkValue("TST destination", dmem[6], 32'h5A);
    checkValue("MOVEQ after zero TST", dmem[7], 32'h66);
  endtask

  task automatic testBranches;
    beginProgram();
    emitImm(CondAl, CmdMov, 1'b0, 4'd1, 4'd0, 8'h11);
    // R2 holds the poison value for every skipped store
    emitImm(CondAl, CmdMov, 1'b0, 4'd2, 4'd0, PoisonValue[7:0]);
    // Offset 1 lands three words past the branch
    emit(branchWord(CondAl, 24'd1));
    emitStore(4'd2, 12'd0);
    emitStore(4'd2, 12'd0);
    emitStore(4'd1, 12'd0);
    emitImm(CondAl, CmdCmp, 1'b1, 4'd0, 4'd1, 8'h11);
    emit(branchWord(CondNe, 24'd1));
    emitImm(CondAl, CmdMov, 1'b0, 4'd3, 4'd0, 8'h22);
    emitStore(4'd3, 12'd4);
    emit(branchWord(CondEq, 24'd1));
    emitStore(4'd2, 12'd8);
    emitStore(4'd2, 12'd8);
    emitStore(4'd1, 12'd8);
    runProgram();
    checkValue("word after taken B", dmem[0], 32'h11);
    checkValue("fall through of BNE", dmem[1], 32'h22);
    checkValue("word after taken BEQ", dmem[2], 32'h11);
    checkValue("poison store seen", {31'd0, poisonSeen}, 32'd0);
    for (int i = 0; i < 64; i++) begin
      checkValue($sformatf("dmem[%0d] poison", i), {31'd0, dmem[i] == PoisonValue}, 32'd0);
    end
  endtask

  initial begin
    clk = 1'b0;
    rstN = 1'b0;
    lfsrState = 32'h2d27;
    progLen = 0;
    poisonSeen = 1'b0;
    testReset();
    testArithmetic();
    testForwarding();
    testLoadUse();
    testFlags();
    testBranches();
    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire
